//--- dv/aabbHitTb.sv
/* Testbench for the ray-box unit. Streams a table of rays and boxes through the
   pipeline and checks each hit record against a reference model. */
module aabbHitTb;
    import fixedPkg::*;
    import rayPkg::*;

    localparam int numRows = 12;
    localparam int waitLimit = 50;
    localparam fixedT big = 32'sh0100_0000;  // 256.0 as a zero-safe reciprocal
    localparam fixedT half = 32'sh0000_8000;

    typedef struct packed {
        rayT   ray;
        primT  prim;
        logic  expHit;
        fixedT expT;
        norm3T expNorm;
    } rowT;

    logic    clk;
    logic    rstN;
    logic    inValid;
    logic    inReady;
    rayT     ray;
    primT    prim;
    logic    outValid;
    logic    outReady;
    hitDataT hitData;

    rowT         rows[numRows];
    int          sendCycle[numRows];
    int          cycleCount = 0;
    int          errorCount = 0;
    int          testsRun = 0;
    int          testsFailed = 0;
    logic        timedOut = 1'b0;
    logic [15:0] lfsr = 16'd52223;

    aabbHitUnit #(
        .fracBits(16)
    ) uut (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
    end

    // --------------------
    // Helpers
    // --------------------
    function automatic fixedT fx(input int n);
        return fixedT'(n) <<< 16;
    endfunction

    // Galois LFSR with taps x^16 + x^14 + x^13 + x^11
    function automatic logic lfsrBit();
        logic b;
        b = lfsr[0];
        lfsr = lfsr >> 1;
        if (b) begin
            lfsr = lfsr ^ 16'hB400;
        end
        return b;
    endfunction

    // Reference model of slab test, interval and hit rules
    function automatic hitDataT refHit(input rayT r, input primT p);
        hitDataT h;
        fixedT   tn[3];
        fixedT   tf[3];
        fixedT   lo;
        fixedT   hi;
        fixedT   entry;
        fixedT   exitD;
        fixedT   t;
        fixedT   minT;
        fixedT   maxT;
        longint  inv;
        h = '0;
        entry = 32'sh8000_0000;
        exitD = 32'sh7FFF_FFFF;
        minT = r.minT;
        maxT = r.maxT;
        for (int a = 0; a < 3; a++) begin
            inv = $signed(r.invDir[a]);
            tn[a] = fixedT'(((longint'($signed(p.box.minCorner[a])) - $signed(r.orig[a])) * inv)
                            >>> 16);
            tf[a] = fixedT'(((longint'($signed(p.box.maxCorner[a])) - $signed(r.orig[a])) * inv)
                            >>> 16);
            lo = (tn[a] < tf[a]) ? tn[a] : tf[a];
            hi = (tn[a] < tf[a]) ? tf[a] : tn[a];
            entry = (lo > entry) ? lo : entry;
            exitD = (hi < exitD) ? hi : exitD;
        end
        t = (entry > 0) ? entry : exitD;
        h.hit = (entry < exitD) && (exitD > 0) && (maxT < 0 || (t >= minT && t <= maxT)) &&
                !p.index[15] && (p.index != r.primIndex);
        h.t = t;
        h.primIndex = h.hit ? p.index : nullPrimIndex;
        h.colour = h.hit ? p.colour : '0;
        h.surfaceType = h.hit ? p.surfaceType : stDiffuse;
        for (int a = 0; a < 3; a++) begin
            if (h.hit && t == tn[a] && $signed(r.dir[a]) > 0) begin
                h.normal[a] = normT'(-1);
            end else if (h.hit && t == tf[a] && $signed(r.dir[a]) < 0) begin
                h.normal[a] = normT'(1);
            end
        end
        return h;
    endfunction

    task automatic checkValue(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("** Error: %s got 0x%0h expected 0x%0h", name, got, exp);
            errorCount++;
        end
    endtask

    task automatic endTest(input string name, input int errorsBefore);
        testsRun++;
        if (errorCount != errorsBefore) begin
            testsFailed++;
        end
        $display("Test %-10s %0d errors", name, errorCount - errorsBefore);
    endtask

    // --------------------
    // Stimulus table
    // --------------------
    task automatic setRow(input int i, input int o[3], input int d[3], input int minT,
                          input int maxT, input primIndexT rayPrim, input int bMin[3],
                          input int bMax[3], input primIndexT index, input logic expHit,
                          input fixedT expT, input norm3T expNorm);
        for (int a = 0; a < 3; a++) begin
            rows[i].ray.orig[a] = fx(o[a]);
            rows[i].ray.dir[a] = fx(d[a]);
            // Exact reciprocals only
            rows[i].ray.invDir[a] = (d[a] == 0) ? big : ((d[a] == 2) ? half : fx(d[a]));
            rows[i].prim.box.minCorner[a] = fx(bMin[a]);
            rows[i].prim.box.maxCorner[a] = fx(bMax[a]);
        end
        rows[i].ray.minT = fx(minT);
        rows[i].ray.maxT = fx(maxT);
        rows[i].ray.primIndex = rayPrim;
        rows[i].prim.colour = {8'(i * 16 + 1), 8'h80, 8'(255 - i)};
        rows[i].prim.index = index;
        rows[i].prim.surfaceType = surfaceTypeE'(i % 4);
        rows[i].expHit = expHit;
        rows[i].expT = expT;
        rows[i].expNorm = expNorm;
    endtask

    // Normals pack axis 0 in the low bits where 2'b11 is -1 and 2'b01 is +1
    task automatic buildTable();
        setRow(0, '{0, 0, 0}, '{1, 0, 0}, 0, -1, nullPrimIndex, '{2, -1, -1}, '{4, 1, 1},
               16'd5, 1'b1, fx(2), 6'h03);
        setRow(1, '{0, 0, 0}, '{1, 0, 0}, 0, -1, nullPrimIndex, '{2, 2, -1}, '{4, 3, 1},
               16'd6, 1'b0, fx(0), 6'h00);
        setRow(2, '{0, 0, 0}, '{-1, 0, 0}, 0, -1, nullPrimIndex, '{2, -1, -1}, '{4, 1, 1},
               16'd7, 1'b0, fx(0), 6'h00);
        // Origin inside so the hit is at the exit
        setRow(3, '{3, 0, 0}, '{1, 0, 0}, 0, -1, nullPrimIndex, '{2, -1, -1}, '{4, 1, 1},
               16'd8, 1'b1, fx(1), 6'h00);
        setRow(4, '{0, 0, 0}, '{1, 0, 0}, 0, 1, nullPrimIndex, '{2, -1, -1}, '{4, 1, 1},
               16'd9, 1'b0, fx(0), 6'h00);
        setRow(5, '{0, 0, 0}, '{1, 0, 0}, 0, 3, nullPrimIndex, '{2, -1, -1}, '{4, 1, 1},
               16'd10, 1'b1, fx(2), 6'h03);
        // Self hit and empty slot
        setRow(6, '{0, 0, 0}, '{1, 0, 0}, 0, -1, 16'd11, '{2, -1, -1}, '{4, 1, 1},
               16'd11, 1'b0, fx(0), 6'h00);
        setRow(7, '{0, 0, 0}, '{1, 0, 0}, 0, -1, nullPrimIndex, '{2, -1, -1}, '{4, 1, 1},
               16'h800B, 1'b0, fx(0), 6'h00);
        setRow(8, '{3, 5, 0}, '{0, -1, 0}, 0, -1, nullPrimIndex, '{2, -1, -1}, '{4, 1, 1},
               16'd12, 1'b1, fx(4), 6'h04);
        setRow(9, '{3, 0, -4}, '{0, 0, 2}, 0, -1, nullPrimIndex, '{2, -1, -1}, '{4, 1, 1},
               16'd13, 1'b1, fx(1) + half, 6'h30);
        setRow(10, '{0, 0, 0}, '{1, 1, 0}, 0, -1, nullPrimIndex, '{1, 2, -1}, '{3, 4, 1},
               16'd14, 1'b1, fx(2), 6'h0C);
        setRow(11, '{0, 0, 0}, '{1, 0, 0}, 3, 5, nullPrimIndex, '{2, -1, -1}, '{4, 1, 1},
               16'd15, 1'b0, fx(0), 6'h00);
    endtask

    // --------------------
    // Streaming
    // --------------------
    task automatic sendRows(input logic gaps);
        int waitCount;
        for (int i = 0; i < numRows && !timedOut; i++) begin
            if (gaps && lfsrBit()) begin
                @(negedge clk);
                inValid = 1'b0;
                #1;
            end
            @(negedge clk);
            inValid = 1'b1;
            ray = rows[i].ray;
            prim = rows[i].prim;
            #1;
            waitCount = 0;
            while (!inReady && !timedOut) begin
                waitCount++;
                if (waitCount > waitLimit) begin
                    $display("Timeout: input row %0d was never accepted", i);
                    errorCount++;
                    timedOut = 1'b1;
                end
                @(negedge clk);
                #1;
            end
            // Transfer happens on the coming rising edge
            sendCycle[i] = cycleCount;
        end
        @(negedge clk);
        inValid = 1'b0;
    endtask

    task automatic collectRows(input logic fullRate);
        int      waitCount;
        hitDataT exp;
        for (int i = 0; i < numRows && !timedOut; i++) begin
            exp = refHit(rows[i].ray, rows[i].prim);
            waitCount = 0;
            do begin
                @(negedge clk);
                if (fullRate) begin
                    outReady = 1'b1;
                end else begin
                    outReady = lfsrBit();
                end
                #1;
                waitCount++;
            end while (!(outValid && outReady) && waitCount < waitLimit && !timedOut);
            if (outValid && outReady) begin
                checkValue($sformatf("row%0d.hit", i), hitData.hit, exp.hit);
                checkValue($sformatf("row%0d.primIndex", i), hitData.primIndex, exp.primIndex);
                checkValue($sformatf("row%0d.colour", i), hitData.colour, exp.colour);
                checkValue($sformatf("row%0d.normal", i), hitData.normal, exp.normal);
                if (exp.hit) begin
                    checkValue($sformatf("row%0d.t", i), hitData.t, exp.t);
                    checkValue($sformatf("row%0d.surfaceType", i), hitData.surfaceType,
                               exp.surfaceType);
                end
                if (fullRate) begin
                    checkValue($sformatf("row%0d.latency", i), cycleCount - sendCycle[i], 3);
                end
            end else if (!timedOut) begin
                $display("Timeout: no result arrived for row %0d", i);
                errorCount++;
                timedOut = 1'b1;
            end
        end
        // No result may follow the last one
        if (!timedOut) begin
            for (int c = 0; c < 5; c++) begin
                @(negedge clk);
                outReady = 1'b1;
                #1;
                checkValue("outValid", outValid, 1'b0);
            end
        end
    endtask

    // --------------------
    // Main sequence
    // --------------------
    initial begin
        int      errorsBefore;
        hitDataT refRec;
        rstN = 1'b0;
        inValid = 1'b0;
        outReady = 1'b0;
        ray = '0;
        prim = '0;
        buildTable();
        repeat (2) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;
        #1;

        errorsBefore = errorCount;
        checkValue("outValid", outValid, 1'b0);
        checkValue("inReady", inReady, 1'b1);
        endTest("reset", errorsBefore);

        // Table expectations against the reference model
        errorsBefore = errorCount;
        for (int i = 0; i < numRows; i++) begin
            refRec = refHit(rows[i].ray, rows[i].prim);
            checkValue($sformatf("table%0d.hit", i), refRec.hit, rows[i].expHit);
            checkValue($sformatf("table%0d.normal", i), refRec.normal, rows[i].expNorm);
            if (rows[i].expHit) begin
                checkValue($sformatf("table%0d.t", i), refRec.t, rows[i].expT);
            end
        end
        endTest("table", errorsBefore);

        errorsBefore = errorCount;
        fork
            sendRows(1'b1);
            collectRows(1'b0);
        join
        endTest("random", errorsBefore);

        errorsBefore = errorCount;
        fork
            sendRows(1'b0);
            collectRows(1'b1);
        join
        endTest("fullRate", errorsBefore);

        $display("Tests %0d, failed %0d, errors %0d", testsRun, testsFailed, errorCount);
        if (errorCount == 0 && !timedOut) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

//--- hdl/aabbHitUnit.sv
/* Top level of the pipelined ray-box intersection unit. One ray and box go
   in per transfer and one hit record comes out, in order. */
module aabbHitUnit #(
    parameter int fracBits = 16
) (
    input  logic            clk,
    input  logic            rstN,
    input  logic            inValid,
    output logic            inReady,
    input  rayPkg::rayT     ray,
    input  rayPkg::primT    prim,
    output logic            outValid,
    input  logic            outReady,
    output rayPkg::hitDataT hitData
);
    import rayPkg::*;

    queryT query;

    // Ray and primitive travel down the pipe as one query
    assign query.ray = ray;
    assign query.prim = prim;

    stageIf s12 ();
    stageIf s23 ();

    // --------------------
    // Stage chain
    // --------------------
    slabDistance #(
        .fracBits(fracBits)
    ) s1 (
        .clk    (clk),
        .rstN   (rstN),
        .inValid(inValid),
        .inReady(inReady),
        .query  (query),
        .down   (s12.src)
    );

    intervalReduce s2 (
        .clk (clk),
        .rstN(rstN),
        .up  (s12.dst),
        .down(s23.src)
    );

    hitResolve s3 (
        .clk     (clk),
        .rstN    (rstN),
        .up      (s23.dst),
        .outValid(outValid),
        .outReady(outReady),
        .hitData (hitData)
    );

endmodule

//--- hdl/fixedPkg.sv
/* Fixed-point scalar, vector and unit-normal types for the ray-box pipeline.
   Import into any module that does fixed-point arithmetic or builds normals. */
package fixedPkg;

    // --------------------
    // Scalar
    // --------------------
    localparam int fixedWidth = 32;

    // Binary point set by the fracBits parameter of the user
    typedef logic signed [fixedWidth-1:0] fixedT;

    // Full-width product before realignment
    typedef logic signed [2*fixedWidth-1:0] fixedWideT;

    localparam fixedT fixedZero = '0;

    // --------------------
    // Vectors
    // --------------------
    // Axis 0..2, elements keep their sign
    typedef fixedT [2:0] fixed3T;

    // Unit component, only -1, 0 or +1
    typedef logic signed [1:0] normT;

    typedef normT [2:0] norm3T;

    localparam normT normZero = normT'(0);
    localparam normT normPos = normT'(1);
    localparam normT normNeg = normT'(-1);

endpackage

//--- hdl/hitResolve.sv
/* Stage 3 of the ray-box unit. Decides hit or miss, picks the hit distance
   and face normal, and registers the finished hit record. */
module hitResolve (
    input  logic            clk,
    input  logic            rstN,
    stageIf.dst             up,
    output logic            outValid,
    input  logic            outReady,
    output rayPkg::hitDataT hitData
);
    import fixedPkg::*;
    import rayPkg::*;

    logic    validQ;
    hitDataT hitQ;
    hitDataT hitNext;
    fixedT   hitT;
    logic    entryAhead;
    logic    unbounded;
    logic    inRange;
    logic    geomHit;
    logic    primOk;
    logic    isHit;

    // --------------------
    // Hit decision
    // --------------------
    always_comb begin
        // Origin inside the box means the entry lies behind, use the exit
        entryAhead = up.entryT > fixedZero;
        hitT = entryAhead ? up.entryT : up.exitT;

        unbounded = up.query.ray.maxT < fixedZero;
        inRange = (hitT >= up.query.ray.minT) && (hitT <= up.query.ray.maxT);
        geomHit = (up.entryT < up.exitT) && (up.exitT > fixedZero) && (unbounded || inRange);

        // Skip empty slots and the surface the ray leaves from
        primOk = !up.query.prim.index[primIndexWidth-1] &&
                 (up.query.prim.index != up.query.ray.primIndex);
        isHit = geomHit && primOk;

        hitNext.hit = isHit;
        hitNext.t = hitT;
        hitNext.primIndex = isHit ? up.query.prim.index : nullPrimIndex;
        hitNext.colour = isHit ? up.query.prim.colour : '0;
        hitNext.surfaceType = isHit ? up.query.prim.surfaceType : stDiffuse;

        // Face normal, only the plane that gave the hit distance
        for (int a = 0; a < 3; a++) begin
            if (isHit && hitT == up.tNear[a] && up.query.ray.dir[a] > fixedZero) begin
                hitNext.normal[a] = normNeg;
            end else if (isHit && hitT == up.tFar[a] && up.query.ray.dir[a] < fixedZero) begin
                hitNext.normal[a] = normPos;
            end else begin
                hitNext.normal[a] = normZero;
            end
        end
    end

    // --------------------
    // Output register
    // --------------------
    assign up.ready = !validQ || outReady;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            validQ <= 1'b0;
        end else if (up.ready) begin
            validQ <= up.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (up.valid && up.ready) begin
            hitQ <= hitNext;
        end
    end

    assign outValid = validQ;
    assign hitData = hitQ;

endmodule

//--- hdl/intervalReduce.sv
/* Stage 2 of the ray-box unit. Folds the six plane distances into the entry
   and exit distance of the ray through the box. */
module intervalReduce (
    input logic clk,
    input logic rstN,
    stageIf.dst up,
    stageIf.src down
);
    import fixedPkg::*;

    logic  validQ;
    fixedT lo[3];
    fixedT hi[3];
    fixedT entryNext;
    fixedT exitNext;

    always_comb begin
        // Order each slab, the direction sign may swap near and far
        for (int a = 0; a < 3; a++) begin
            lo[a] = (up.tNear[a] < up.tFar[a]) ? up.tNear[a] : up.tFar[a];
            hi[a] = (up.tNear[a] < up.tFar[a]) ? up.tFar[a] : up.tNear[a];
        end

        // Latest entry over all slabs
        entryNext = (lo[0] > lo[1]) ? lo[0] : lo[1];
        entryNext = (lo[2] > entryNext) ? lo[2] : entryNext;

        // Earliest exit
        exitNext = (hi[0] < hi[1]) ? hi[0] : hi[1];
        exitNext = (hi[2] < exitNext) ? hi[2] : exitNext;
    end

    // --------------------
    // Output register
    // --------------------
    assign up.ready = !validQ || down.ready;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            validQ <= 1'b0;
        end else if (up.ready) begin
            validQ <= up.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (up.valid && up.ready) begin
            down.query <= up.query;
            down.tNear <= up.tNear;
            down.tFar <= up.tFar;
            down.entryT <= entryNext;
            down.exitT <= exitNext;
        end
    end

    assign down.valid = validQ;

endmodule

//--- hdl/rayPkg.sv
/* Ray, box, primitive and hit-record types shared by the stages and the testbench.
   Builds on the fixed-point types. */
package rayPkg;
    import fixedPkg::*;

    // --------------------
    // Primitive attributes
    // --------------------
    localparam int primIndexWidth = 16;

    // Top bit set means no primitive
    typedef logic [primIndexWidth-1:0] primIndexT;

    localparam primIndexT nullPrimIndex = '1;

    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } rgb8T;

    typedef enum logic [1:0] {
        stDiffuse,
        stSpecular,
        stRefractive,
        stEmissive
    } surfaceTypeE;

    // --------------------
    // Query and result
    // --------------------
    typedef struct packed {
        fixed3T    orig;
        fixed3T    dir;
        fixed3T    invDir;
        fixedT     minT;
        fixedT     maxT;      // Negative for an unbounded ray
        primIndexT primIndex; // Primitive the ray starts from
    } rayT;

    typedef struct packed {
        fixed3T minCorner;
        fixed3T maxCorner;
    } aabbT;

    typedef struct packed {
        aabbT        box;
        rgb8T        colour;
        primIndexT   index;
        surfaceTypeE surfaceType;
    } primT;

    typedef struct packed {
        rayT  ray;
        primT prim;
    } queryT;

    typedef struct packed {
        logic        hit;
        fixedT       t;
        primIndexT   primIndex;
        rgb8T        colour;
        surfaceTypeE surfaceType;
        norm3T       normal;
    } hitDataT;

endpackage

//--- hdl/slabDistance.sv
/* Stage 1 of the ray-box unit. Computes the distance along the ray to the
   near and far box planes on each axis and registers them with the query. */
module slabDistance #(
    parameter int fracBits = 16
) (
    input  logic          clk,
    input  logic          rstN,
    input  logic          inValid,
    output logic          inReady,
    input  rayPkg::queryT query,
    stageIf.src           down
);
    import fixedPkg::*;

    logic      validQ;
    fixedT     nearDiff[3];
    fixedT     farDiff[3];
    fixedWideT nearProd[3];
    fixedWideT farProd[3];
    fixedT     nearNext[3];
    fixedT     farNext[3];

    // --------------------
    // Slab arithmetic
    // --------------------
    always_comb begin
        for (int a = 0; a < 3; a++) begin
            nearDiff[a] = query.prim.box.minCorner[a] - query.ray.orig[a];
            farDiff[a] = query.prim.box.maxCorner[a] - query.ray.orig[a];
            nearProd[a] = fixedWideT'(nearDiff[a]) * fixedWideT'(query.ray.invDir[a]);
            farProd[a] = fixedWideT'(farDiff[a]) * fixedWideT'(query.ray.invDir[a]);
            // Drop the extra fraction bits of the product
            nearNext[a] = fixedT'(nearProd[a] >>> fracBits);
            farNext[a] = fixedT'(farProd[a] >>> fracBits);
        end
    end

    // --------------------
    // Output register
    // --------------------
    assign inReady = !validQ || down.ready;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            validQ <= 1'b0;
        end else if (inReady) begin
            validQ <= inValid;
        end
    end

    always_ff @(posedge clk) begin
        if (inValid && inReady) begin
            down.query <= query;
            down.tNear <= nearNext;
            down.tFar <= farNext;
        end
    end

    assign down.valid = validQ;

endmodule

//--- hdl/stageIf.sv
/* Valid/ready link between pipeline stages. Carries the query and the slab
   results built up so far; each stage fills in its own fields. */
interface stageIf;
    import fixedPkg::*;
    import rayPkg::*;

    logic  valid;
    logic  ready;
    queryT query;

    // Plane distances per axis, from stage 1
    fixedT tNear[3];
    fixedT tFar[3];

    // Interval bounds, from stage 2
    fixedT entryT;
    fixedT exitT;

    modport src (
        output valid,
        output query,
        output tNear,
        output tFar,
        output entryT,
        output exitT,
        input  ready
    );

    modport dst (
        input  valid,
        input  query,
        input  tNear,
        input  tFar,
        input  entryT,
        input  exitT,
        output ready
    );

endinterface

//--- src.f
hdl/fixedPkg.sv
hdl/rayPkg.sv
hdl/stageIf.sv
hdl/slabDistance.sv
hdl/intervalReduce.sv
hdl/hitResolve.sv
hdl/aabbHitUnit.sv
dv/aabbHitTb.sv
